// ==== dv/fetch_golden.txt ====
# p <addr> <word>   program word written through the load port during reset
# f <entry> <excep_entry>   flush pulsed after that trace entry (0-based) pops
# e <test> <pc> <inst> <adef>   expected trace entry, in output order
p 1c000000 00100001
p 1c000004 00200002
p 1c000008 00300003
p 1c00000c 50000006
p 1c000010 50000002
p 1c000024 00400024
p 1c000028 50000008
p 1c000048 00500048
p 1c00004c 0060004c
p 1c000050 00700050
p 1c000054 50000004
p 1c000064 00800064
p 1c000068 00900068
p 1c00006c 00a0006c
p 1c000200 00b00200
p 1c000204 00c00204
p 1c000208 00d00208
p 1c000300 50000006
p 1c000318 00e00318
p 1c000380 00f00380
p 1c000384 01000384
e 1 1c000000 00100001 0
e 1 1c000004 00200002 0
e 1 1c000008 00300003 0
e 2 1c00000c 50000006 0
e 2 1c000024 00400024 0
e 2 1c000028 50000008 0
e 2 1c000048 00500048 0
e 3 1c00004c 0060004c 0
e 3 1c000050 00700050 0
e 3 1c000054 50000004 0
e 3 1c000064 00800064 0
e 3 1c000068 00900068 0
e 3 1c00006c 00a0006c 0
f 12 1c000200
e 4 1c000200 00b00200 0
e 4 1c000204 00c00204 0
e 4 1c000208 00d00208 0
f 15 1c000302
e 5 1c000302 50000006 1
e 5 1c00031a 00e00318 1
f 17 1c000380
e 5 1c000380 00f00380 0
e 5 1c000384 01000384 0

// ==== sources.f ====
common/fetch_pkg.sv
logic/inst_ram.sv
fetch/fetch_stage.sv
logic/branch_decode.sv
logic/trace_queue.sv
logic/fetch_top.sv
dv/tb_fetch_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run tb_fetch_top with Verilator, output goes to sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_fetch_top \
    -o tb_fetch_top > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }

./obj_dir/tb_fetch_top > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }

cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
echo "simulation finished without failure"
exit 0

// ==== dv/tb_fetch_top.sv ====
`timescale 1ns/1ps

module tb_fetch_top;
    import fetch_pkg::*;

    localparam int wait_limit = 200;    // cycles allowed per trace entry

    logic              clk;
    logic              resetn;
    logic              flush;
    logic [inst_w-1:0] excep_entry;
    logic              out_ready;
    logic              load_en;
    logic [inst_w-1:0] load_addr;
    logic [inst_w-1:0] load_data;
    logic              out_valid;
    logic [inst_w-1:0] out_pc;
    logic [inst_w-1:0] out_inst;
    logic              out_adef;

    // contents of the golden file
    logic [inst_w-1:0] prog_addr   [$];
    logic [inst_w-1:0] prog_word   [$];
    int                flush_after [$];
    logic [inst_w-1:0] flush_entry [$];
    int                exp_test    [$];
    logic [inst_w-1:0] exp_pc      [$];
    logic [inst_w-1:0] exp_inst    [$];
    logic              exp_adef    [$];

    integer seed      = 32'hb68a_8aa8;
    int     errors    = 0;
    int     checked   = 0;
    bit     timed_out = 1'b0;
    bit     setup_ok  = 1'b1;

    fetch_top u_dut (
        .clk         (clk),
        .resetn      (resetn),
        .flush       (flush),
        .excep_entry (excep_entry),
        .out_ready   (out_ready),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .out_valid   (out_valid),
        .out_pc      (out_pc),
        .out_inst    (out_inst),
        .out_adef    (out_adef)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic string test_label(input int test);
        case (test)
            1:       return "sequential fetch";
            2:       return "branch redirect";
            3:       return "back-pressure";
            4:       return "flush";
            default: return "address error";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [inst_w-1:0] got,
                               input logic [inst_w-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // sequential test keeps the port open, the rest stall 3 cycles in 4
    task automatic drive_ready(input int test);
        logic [31:0] rnd;
        rnd = $random(seed);
        if (test == 1) begin
            out_ready <= 1'b1;
        end else begin
            out_ready <= (rnd[1:0] == 2'b00);
        end
    endtask

    // returns at the falling edge before the pop, outputs are settled there
    task automatic wait_entry(input int test, output bit got);
        int cycles;
        got = 1'b0;
        cycles = 0;
        while (!got && cycles < wait_limit) begin
            @(negedge clk);
            if (out_valid && out_ready) begin
                got = 1'b1;
            end else begin
                @(posedge clk);
                flush <= 1'b0;
                drive_ready(test);
                cycles++;
            end
        end
    endtask

    task automatic read_golden();
        int                fd;
        int                n;
        int                idx;
        int                adef;
        logic [7:0]        kind;
        logic [8*128-1:0]  rest;
        logic [inst_w-1:0] a;
        logic [inst_w-1:0] d;
        fd = $fopen("dv/fetch_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/fetch_golden.txt");
            setup_ok = 1'b0;
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind == "#") begin
                    n = $fgets(rest, fd);
                end else if (kind == "p") begin
                    n = $fscanf(fd, "%h %h", a, d);
                    setup_ok &= (n == 2);
                    prog_addr.push_back(a);
                    prog_word.push_back(d);
                end else if (kind == "f") begin
                    n = $fscanf(fd, "%d %h", idx, a);
                    setup_ok &= (n == 2);
                    flush_after.push_back(idx);
                    flush_entry.push_back(a);
                end else if (kind == "e") begin
                    n = $fscanf(fd, "%d %h %h %d", idx, a, d, adef);
                    setup_ok &= (n == 4);
                    exp_test.push_back(idx);
                    exp_pc.push_back(a);
                    exp_inst.push_back(d);
                    exp_adef.push_back(adef[0]);
                end else begin
                    setup_ok = 1'b0;
                end
            end
            $fclose(fd);
            if (!setup_ok || exp_pc.size() == 0) begin
                $display("golden file is malformed or holds no expected trace");
                setup_ok = 1'b0;
            end
        end
    endtask

    // whole RAM gets an address pattern first, then the program words
    task automatic load_program();
        for (int i = 0; i < ram_words; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= ram_base + 32'(4 * i);
            load_data <= ~(ram_base + 32'(4 * i));  // top bits 111000, never a branch
        end
        foreach (prog_addr[i]) begin
            @(posedge clk);
            load_addr <= prog_addr[i];
            load_data <= prog_word[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    initial begin
        bit got;
        int fi;
        int count;
        int err_mark;
        resetn      = 1'b0;
        flush       = 1'b0;
        excep_entry = '0;
        out_ready   = 1'b0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        fi          = 0;
        count       = 0;
        err_mark    = 0;
        read_golden();
        if (setup_ok) begin
            load_program();
            repeat (3) @(posedge clk);
            resetn <= 1'b1;
            drive_ready(exp_test[0]);
            for (int i = 0; i < exp_pc.size() && !timed_out; i++) begin
                wait_entry(exp_test[i], got);
                if (!got) begin
                    $display("timeout: trace entry %0d did not appear within %0d cycles",
                             i, wait_limit);
                    timed_out = 1'b1;
                end else begin
                    check_value("out_pc", out_pc, exp_pc[i]);
                    check_value("out_inst", out_inst, exp_inst[i]);
                    check_value("out_adef", inst_w'(out_adef), inst_w'(exp_adef[i]));
                    checked++;
                    count++;
                    if (i == exp_pc.size() - 1 || exp_test[i + 1] != exp_test[i]) begin
                        $display("test %0d %s: %0d entries, %0d errors", exp_test[i],
                                 test_label(exp_test[i]), count, errors - err_mark);
                        count    = 0;
                        err_mark = errors;
                    end
                    @(posedge clk);
                    if (fi < flush_after.size() && flush_after[fi] == i) begin
                        flush       <= 1'b1;
                        excep_entry <= flush_entry[fi];
                        out_ready   <= 1'b0;    // no pop in the flush cycle
                        fi++;
                    end else if (i + 1 < exp_pc.size()) begin
                        drive_ready(exp_test[i + 1]);
                    end
                end
            end
        end
        $display("%0d of %0d trace entries checked, %0d errors",
                 checked, exp_pc.size(), errors);
        if (setup_ok && !timed_out && errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          flush,
    input  logic [fetch_pkg::inst_w-1:0]  excep_entry,
    input  logic                          out_ready,
    input  logic                          load_en,
    input  logic [fetch_pkg::inst_w-1:0]  load_addr,
    input  logic [fetch_pkg::inst_w-1:0]  load_data,
    output logic                          out_valid,
    output logic [fetch_pkg::inst_w-1:0]  out_pc,
    output logic [fetch_pkg::inst_w-1:0]  out_inst,
    output logic                          out_adef
);
    import fetch_pkg::*;

    // fetch <-> RAM
    logic              req;
    logic [inst_w-1:0] addr;
    logic              addr_ok;
    logic              data_ok;
    logic [inst_w-1:0] rdata;

    // fetch <-> decode
    logic              if_valid_out;
    logic [inst_w-1:0] if_pc;
    logic [inst_w-1:0] if_inst;
    logic              if_adef;
    logic              id_allowin;
    logic              br_taken;
    logic [inst_w-1:0] br_target;

    // decode -> queue
    logic              id_valid_out;
    logic [inst_w-1:0] id_pc;
    logic [inst_w-1:0] id_inst;
    logic              id_adef;
    logic              not_full;

    inst_ram u_inst_ram (
        .clk       (clk),
        .resetn    (resetn),
        .req       (req),
        .addr      (addr),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata)
    );

    fetch_stage u_fetch_stage (
        .clk          (clk),
        .resetn       (resetn),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .id_allowin   (id_allowin),
        .br_taken     (br_taken),
        .br_target    (br_target),
        .flush        (flush),
        .excep_entry  (excep_entry),
        .req          (req),
        .addr         (addr),
        .if_valid_out (if_valid_out),
        .if_pc        (if_pc),
        .if_inst      (if_inst),
        .if_adef      (if_adef)
    );

    branch_decode u_branch_decode (
        .clk          (clk),
        .resetn       (resetn),
        .if_valid_out (if_valid_out),
        .if_pc        (if_pc),
        .if_inst      (if_inst),
        .if_adef      (if_adef),
        .not_full     (not_full),
        .flush        (flush),
        .id_allowin   (id_allowin),
        .br_taken     (br_taken),
        .br_target    (br_target),
        .id_valid_out (id_valid_out),
        .id_pc        (id_pc),
        .id_inst      (id_inst),
        .id_adef      (id_adef)
    );

    trace_queue u_trace_queue (
        .clk       (clk),
        .resetn    (resetn),
        .flush     (flush),
        .push      (id_valid_out),
        .push_pc   (id_pc),
        .push_inst (id_inst),
        .push_adef (id_adef),
        .out_ready (out_ready),
        .not_full  (not_full),
        .out_valid (out_valid),
        .out_pc    (out_pc),
        .out_inst  (out_inst),
        .out_adef  (out_adef)
    );

endmodule

// ==== logic/trace_queue.sv ====
`timescale 1ns/1ps

module trace_queue (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          flush,
    input  logic                          push,
    input  logic [fetch_pkg::inst_w-1:0]  push_pc,
    input  logic [fetch_pkg::inst_w-1:0]  push_inst,
    input  logic                          push_adef,
    input  logic                          out_ready,
    output logic                          not_full,
    output logic                          out_valid,
    output logic [fetch_pkg::inst_w-1:0]  out_pc,
    output logic [fetch_pkg::inst_w-1:0]  out_inst,
    output logic                          out_adef
);
    import fetch_pkg::*;

    logic [inst_w-1:0]      pc_mem   [queue_depth];
    logic [inst_w-1:0]      inst_mem [queue_depth];
    logic                   adef_mem [queue_depth];
    logic [queue_ptr_w-1:0] wr_ptr;
    logic [queue_ptr_w-1:0] rd_ptr;
    logic [queue_ptr_w:0]   count;
    logic                   wr_en;
    logic                   rd_en;

    assign not_full  = count != (queue_ptr_w + 1)'(queue_depth);
    assign out_valid = count != '0;
    assign wr_en     = push & not_full;
    assign rd_en     = out_valid & out_ready;

    assign out_pc   = pc_mem[rd_ptr];
    assign out_inst = inst_mem[rd_ptr];
    assign out_adef = adef_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            pc_mem[wr_ptr]   <= push_pc;
            inst_mem[wr_ptr] <= push_inst;
            adef_mem[wr_ptr] <= push_adef;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;    // depth is a power of two, wraps
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    // a push held against a full queue is neither taken nor lost
    a_full_hold: assert property (@(posedge clk) disable iff (!resetn)
        push && !not_full && !flush
        |=> push && $stable(push_pc) && $stable(push_inst))
        else $error("push dropped or changed while the trace queue was full");

endmodule

// ==== logic/branch_decode.sv ====
`timescale 1ns/1ps

module branch_decode (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          if_valid_out,
    input  logic [fetch_pkg::inst_w-1:0]  if_pc,
    input  logic [fetch_pkg::inst_w-1:0]  if_inst,
    input  logic                          if_adef,
    input  logic                          not_full,
    input  logic                          flush,
    output logic                          id_allowin,
    output logic                          br_taken,
    output logic [fetch_pkg::inst_w-1:0]  br_target,
    output logic                          id_valid_out,
    output logic [fetch_pkg::inst_w-1:0]  id_pc,
    output logic [fetch_pkg::inst_w-1:0]  id_inst,
    output logic                          id_adef
);
    import fetch_pkg::*;

    logic              id_valid;
    logic              cancel_active;   // wrong path behind a taken branch
    logic [inst_w-1:0] cancel_target;
    logic              accept;
    logic              dropping;
    logic              is_branch;

    assign id_allowin   = ~id_valid | not_full;
    assign id_valid_out = id_valid;
    assign accept       = if_valid_out & id_allowin;

    // drop until the branch target itself shows up
    assign dropping  = cancel_active & (if_pc != cancel_target);
    assign is_branch = if_inst[31:26] == op_branch;

    assign br_taken  = accept & ~dropping & is_branch & ~flush;
    assign br_target = if_pc + {{4{if_inst[25]}}, if_inst[25:0], 2'b00};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (flush) begin
            id_valid <= 1'b0;
        end else if (accept) begin
            id_valid <= ~dropping;  // dropped words are swallowed here
        end else if (not_full) begin
            id_valid <= 1'b0;       // moved into the queue
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !dropping) begin
            id_pc   <= if_pc;
            id_inst <= if_inst;
            id_adef <= if_adef;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cancel_active <= 1'b0;
        end else if (flush) begin
            cancel_active <= 1'b0;
        end else if (br_taken) begin
            cancel_active <= 1'b1;
        end else if (accept && cancel_active && !dropping) begin
            cancel_active <= 1'b0;  // target reached
        end
    end

    always_ff @(posedge clk) begin
        if (br_taken) begin
            cancel_target <= br_target;
        end
    end

    // a fetch word refused by decode waits unchanged
    a_if_hold: assert property (@(posedge clk) disable iff (!resetn)
        if_valid_out && !id_allowin && !flush
        |=> if_valid_out && $stable(if_pc) && $stable(if_inst))
        else $error("fetch word changed while decode stalled");

endmodule

// ==== fetch/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          addr_ok,
    input  logic                          data_ok,
    input  logic [fetch_pkg::inst_w-1:0]  rdata,
    input  logic                          id_allowin,
    input  logic                          br_taken,
    input  logic [fetch_pkg::inst_w-1:0]  br_target,
    input  logic                          flush,
    input  logic [fetch_pkg::inst_w-1:0]  excep_entry,
    output logic                          req,
    output logic [fetch_pkg::inst_w-1:0]  addr,
    output logic                          if_valid_out,
    output logic [fetch_pkg::inst_w-1:0]  if_pc,
    output logic [fetch_pkg::inst_w-1:0]  if_inst,
    output logic                          if_adef
);
    import fetch_pkg::*;

    // IF slot, the older word
    logic              if_valid;        // waiting for or holding a word
    logic              if_inst_valid;   // word already returned, kept in if_ir
    logic [inst_w-1:0] if_ir;

    // pre-IF slot, a younger request issued while IF was busy
    logic              pre_if_reqed;
    logic [inst_w-1:0] pre_if_pc;
    logic              pre_if_ir_valid;
    logic [inst_w-1:0] pre_if_ir;

    // redirects that could not be sent out yet
    logic              br_taken_reg;
    logic [inst_w-1:0] br_target_reg;
    logic              flush_reg;
    logic [inst_w-1:0] excep_entry_reg;

    logic              inst_cancel;     // next data_ok belongs to a flushed request

    logic              req_pending;
    logic              req_fire;
    logic              if_data_ok;
    logic              pre_data_ok;
    logic              if_ready_go;
    logic              if_fire;
    logic              if_keep;
    logic              if_load_pre;
    logic              if_load_req;
    logic              pre_load_req;
    logic [inst_w-1:0] seq_pc;
    logic [inst_w-1:0] pre_pc;

    // anything still owed by the RAM
    assign req_pending = inst_cancel
                       | (pre_if_reqed & ~pre_if_ir_valid)
                       | (if_valid & ~if_inst_valid);

    assign if_data_ok  = data_ok & ~inst_cancel & if_valid & ~if_inst_valid;
    assign pre_data_ok = data_ok & ~inst_cancel & pre_if_reqed & ~pre_if_ir_valid;

    assign if_ready_go  = (if_valid & if_inst_valid) | if_data_ok;
    assign if_valid_out = if_ready_go;
    assign if_fire      = if_ready_go & id_allowin;
    assign if_keep      = if_valid & ~if_fire;      // IF still occupied after this edge
    assign if_inst      = if_inst_valid ? if_ir : rdata;

    // at most two words in flight or buffered, one request outstanding
    assign req      = (~req_pending | data_ok) & (~pre_if_reqed | flush);
    assign req_fire = req & addr_ok;

    // if_pc always holds the last issued address when a sequential fetch can go
    assign seq_pc = if_pc + 32'd4;
    assign pre_pc = flush        ? excep_entry
                  : flush_reg    ? excep_entry_reg
                  : br_taken     ? br_target
                  : br_taken_reg ? br_target_reg
                  : seq_pc;
    assign addr   = pre_pc;

    // where the IF slot gets its next word from
    assign if_load_pre  = ~flush & ~if_keep & pre_if_reqed;
    assign if_load_req  = req_fire & (flush | ~if_keep);
    assign pre_load_req = req_fire & ~flush & if_keep;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_valid <= 1'b0;
        end else if (flush) begin
            if_valid <= req_fire;           // only the entry fetch survives
        end else if (!if_keep) begin
            if_valid <= pre_if_reqed | req_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_pc   <= reset_pc;
            if_adef <= 1'b0;
        end else if (if_load_pre) begin
            if_pc   <= pre_if_pc;
            if_adef <= |pre_if_pc[1:0];
        end else if (if_load_req) begin
            if_pc   <= pre_pc;
            if_adef <= |pre_pc[1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_inst_valid <= 1'b0;
        end else if (flush) begin
            if_inst_valid <= 1'b0;
        end else if (if_load_pre) begin
            if_inst_valid <= pre_if_ir_valid | pre_data_ok;
        end else if (if_load_req || if_fire) begin
            if_inst_valid <= 1'b0;
        end else if (if_data_ok) begin
            if_inst_valid <= 1'b1;          // decode stalled, park the word
        end
    end

    always_ff @(posedge clk) begin
        if (if_load_pre) begin
            if_ir <= pre_if_ir_valid ? pre_if_ir : rdata;
        end else if (if_keep && if_data_ok) begin
            if_ir <= rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pre_if_reqed <= 1'b0;
        end else if (flush || if_load_pre) begin
            pre_if_reqed <= 1'b0;
        end else if (pre_load_req) begin
            pre_if_reqed <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pre_if_ir_valid <= 1'b0;
        end else if (flush || if_load_pre) begin
            pre_if_ir_valid <= 1'b0;
        end else if (pre_data_ok) begin
            pre_if_ir_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pre_load_req) begin
            pre_if_pc <= pre_pc;
        end
        if (pre_data_ok) begin
            pre_if_ir <= rdata;
        end
    end

    // hold redirects until a request carries them
    always_ff @(posedge clk) begin
        if (!resetn) begin
            br_taken_reg <= 1'b0;
            flush_reg    <= 1'b0;
        end else begin
            if (flush || req_fire) begin
                br_taken_reg <= 1'b0;   // a flush overrides any held branch
            end else if (br_taken) begin
                br_taken_reg <= 1'b1;
            end
            if (req_fire) begin
                flush_reg <= 1'b0;
            end else if (flush) begin
                flush_reg <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (br_taken && !req_fire) begin
            br_target_reg <= br_target;
        end
        if (flush && !req_fire) begin
            excep_entry_reg <= excep_entry;
        end
    end

    // a flush with a request still out drops that word when it returns
    always_ff @(posedge clk) begin
        if (!resetn) begin
            inst_cancel <= 1'b0;
        end else if (flush && req_pending && !data_ok) begin
            inst_cancel <= 1'b1;
        end else if (data_ok) begin
            inst_cancel <= 1'b0;
        end
    end

    a_data_expected: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> req_pending)
        else $error("data_ok with no fetch request outstanding");

    a_cancel_quiet: assert property (@(posedge clk) disable iff (!resetn)
        inst_cancel |-> !if_valid_out)
        else $error("cancelled fetch word reached decode");

endmodule

// ==== logic/inst_ram.sv ====
`timescale 1ns/1ps

module inst_ram (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          req,
    input  logic [fetch_pkg::inst_w-1:0]  addr,
    input  logic                          load_en,
    input  logic [fetch_pkg::inst_w-1:0]  load_addr,
    input  logic [fetch_pkg::inst_w-1:0]  load_data,
    output logic                          addr_ok,
    output logic                          data_ok,
    output logic [fetch_pkg::inst_w-1:0]  rdata
);
    import fetch_pkg::*;

    logic [inst_w-1:0]    mem [ram_words];
    logic                 pending;      // one request accepted, data due
    logic                 accept;
    logic [ram_idx_w-1:0] rd_idx;
    logic [ram_idx_w-1:0] ld_idx;

    // low two bits ignored, misaligned reads return the aligned word
    assign rd_idx = addr[ram_idx_w+1:2];
    assign ld_idx = load_addr[ram_idx_w+1:2];

    // new request only when idle or when the old one completes now
    assign data_ok = pending;
    assign addr_ok = ~pending | data_ok;
    assign accept  = req & addr_ok;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pending <= 1'b0;
        end else begin
            pending <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata <= mem[rd_idx];
        end
    end

    // program load, one word per cycle
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[ld_idx] <= load_data;
        end
    end

    // the fetch path only ever reads, stores come in under reset
    a_load_in_reset: assert property (@(posedge clk)
        load_en |-> !resetn)
        else $error("program load while out of reset");

endmodule

// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    // address and instruction width
    localparam int inst_w = 32;

    // instruction RAM window
    localparam logic [inst_w-1:0] ram_base = 32'h1c00_0000;
    localparam int ram_words = 256;
    localparam int ram_idx_w = $clog2(ram_words);   // word index, addr[9:2]

    // if_pc sits one word below the RAM so the first sequential fetch hits ram_base
    localparam logic [inst_w-1:0] reset_pc = ram_base - 32'd4;

    // trace queue toward the output port
    localparam int queue_depth = 4;
    localparam int queue_ptr_w = $clog2(queue_depth);

    // relative branch, inst[31:26]
    // inst[25:0] is a signed word offset from the branch pc
    localparam logic [5:0] op_branch = 6'b010100;

endpackage
